/* hdl/phy_cmd_pkg.sv */
/*
 * phy command package
 * command word layout for the half-rate DDR3 command path, seen either
 * as a DDR command or as a NOP/pause word, plus widths, tristate
 * transition nibbles and the sequencer state encoding
 */
package phy_cmd_pkg;

    localparam int ADDR_W  = 15;    // DDR3 row/column address
    localparam int BANK_W  = 3;
    localparam int PAUSE_W = 6;     // NOP pause length
    localparam int PC_W    = 8;     // command memory address
    localparam int TRI_W   = 8;     // two 4-bit halves per mclk

    // tristate nibbles on the first cycle of a transition
    localparam logic [3:0] DQ_TRI_FIRST  = 4'h7;   // dq, tri -> driven
    localparam logic [3:0] DQ_TRI_LAST   = 4'he;   // dq, driven -> tri
    localparam logic [3:0] DQS_TRI_FIRST = 4'h3;   // dqs, preamble side
    localparam logic [3:0] DQS_TRI_LAST  = 4'hc;   // dqs, postamble side

    // DDR command view, msb first
    typedef struct packed {
        logic [ADDR_W-1:0] addr;    // [31:17]
        logic [BANK_W-1:0] bank;    // [16:14]
        logic [2:0]        rcw;     // positive ras/cas/we, 0 is nop
        logic              odt;
        logic              cke_dis; // xor-ed with ddr_cke
        logic              sel;     // 1 puts command in first half
        logic              dq_en;
        logic              dqs_en;
        logic              dci_en;
        logic              buf_wr;
        logic              buf_rd;
        logic [2:0]        spare;
    } ddr_cmd_t;

    // NOP view, pause and done overlay the address field
    typedef struct packed {
        logic [7:0]         unused;
        logic               done;   // bit 23, end of sequence
        logic [PAUSE_W-1:0] pause;  // [22:17], 0 means no pause
        logic [BANK_W-1:0]  bank;
        logic [2:0]         rcw;    // zero for every nop
        logic               odt;
        logic               cke_dis;
        logic               sel;
        logic               dq_en;
        logic               dqs_en;
        logic               dci_en;
        logic               buf_wr;
        logic               buf_rd;
        logic [2:0]         spare;
    } nop_cmd_t;

    typedef union packed {
        ddr_cmd_t ddr;
        nop_cmd_t nop;
    } cmd_word_t;

    typedef enum logic [2:0] {
        IDLE   = 3'd0,  // waiting for start
        RUN    = 3'd1,  // one fetch per mclk
        PAUSE  = 3'd2,  // fetch stopped, timer running
        RESUME = 3'd3   // refetch after pause
    } seq_state_t;

endpackage

/* hdl/pause_timer.sv */
`timescale 1ns/10ps
/*
 * nop pause timer
 * down-counter loaded from a pausing nop, expired while at zero
 */
module pause_timer (
    input  logic                            mclk,
    input  logic                            rst_in,
    input  logic                            pause_load,     // nop with nonzero pause issued
    input  logic [phy_cmd_pkg::PAUSE_W-1:0] pause_len,
    output logic                            pause_expired
);

    logic [phy_cmd_pkg::PAUSE_W-1:0] cnt;

    assign pause_expired = (cnt == '0);

    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            cnt <= '0;
        end else if (pause_load) begin
            cnt <= pause_len - (phy_cmd_pkg::PAUSE_W)'(1);  // load cycle is the first of p
        end else if (!pause_expired) begin
            cnt <= cnt - (phy_cmd_pkg::PAUSE_W)'(1);
        end
    end

    // sequencer must not start a new pause over a running one
    assert property (@(posedge mclk) disable iff (rst_in)
        pause_load |-> pause_expired);

endmodule

/* hdl/cmd_sequencer.sv */
`timescale 1ns/10ps
/*
 * command fetch sequencer
 * walks the command memory one word per mclk, issues each arriving word,
 * stops fetching for nop pauses and ends the run on a done nop
 */
module cmd_sequencer (
    input  logic                            mclk,
    input  logic                            rst_in,
    input  logic                            start,
    input  phy_cmd_pkg::cmd_word_t          cmd_word,       // valid the cycle after cmd_rd
    input  logic                            pause_expired,
    output logic                            cmd_rd,
    output logic [phy_cmd_pkg::PC_W-1:0]    cmd_addr,
    output logic                            issue,
    output phy_cmd_pkg::cmd_word_t          issue_word,
    output logic                            pause_load,
    output logic [phy_cmd_pkg::PAUSE_W-1:0] pause_len,
    output logic                            busy,
    output logic                            seq_done        // aligned with done nop outputs
);

    phy_cmd_pkg::seq_state_t      state;
    phy_cmd_pkg::seq_state_t      state_nxt;
    logic [phy_cmd_pkg::PC_W-1:0] pc;           // address being fetched
    logic                         inflight;     // word due from memory this cycle
    logic                         word_vld;
    logic                         is_nop;
    logic                         is_done;
    logic                         is_pause;

    // words landing outside RUN are stale fetches
    assign word_vld = inflight && (state == phy_cmd_pkg::RUN);
    assign is_nop   = (cmd_word.ddr.rcw == 3'b000);                 // nop view only then
    assign is_done  = is_nop && cmd_word.nop.done;
    assign is_pause = is_nop && !cmd_word.nop.done && (cmd_word.nop.pause != '0);

    assign cmd_rd     = (state == phy_cmd_pkg::RUN) || (state == phy_cmd_pkg::RESUME);
    assign cmd_addr   = pc;
    assign busy       = (state != phy_cmd_pkg::IDLE);
    assign issue      = word_vld;                   // nops issue too, they set cke/odt/tri
    assign issue_word = cmd_word;
    assign pause_load = word_vld && is_pause;
    assign pause_len  = cmd_word.nop.pause;

    always_comb begin
        state_nxt = state;
        case (state)
            phy_cmd_pkg::IDLE: begin
                if (start) begin
                    state_nxt = phy_cmd_pkg::RUN;
                end
            end
            phy_cmd_pkg::RUN: begin
                if (word_vld && is_done) begin
                    state_nxt = phy_cmd_pkg::IDLE;      // in-flight word dropped
                end else if (pause_load) begin
                    state_nxt = phy_cmd_pkg::PAUSE;
                end
            end
            phy_cmd_pkg::PAUSE: begin
                if (pause_expired) begin
                    state_nxt = phy_cmd_pkg::RESUME;
                end
            end
            phy_cmd_pkg::RESUME: begin
                state_nxt = phy_cmd_pkg::RUN;           // refetch issued, data next cycle
            end
            default: begin
                state_nxt = phy_cmd_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            state    <= phy_cmd_pkg::IDLE;
            pc       <= '0;
            inflight <= 1'b0;
            seq_done <= 1'b0;
        end else begin
            state    <= state_nxt;
            inflight <= cmd_rd;
            seq_done <= word_vld && is_done;            // one cycle pulse
            if ((state == phy_cmd_pkg::IDLE) && start) begin
                pc <= '0;
            end else if (cmd_rd && !pause_load) begin
                pc <= pc + (phy_cmd_pkg::PC_W)'(1);
            end
            // on a pause pc stays on the word after the nop, so its fetch repeats
        end
    end

    // fetch stays off from pause entry until the timer has run out
    assert property (@(posedge mclk) disable iff (rst_in)
        ((state == phy_cmd_pkg::PAUSE) || !pause_expired) |-> !cmd_rd);

    // done only ever closes a running sequence
    assert property (@(posedge mclk) disable iff (rst_in)
        seq_done |-> $past(busy));

endmodule

/* hdl/cmd_slot_encoder.sv */
`timescale 1ns/10ps
/*
 * command slot encoder
 * registers an issued word into two half-cycle phy slots, the unused
 * half and idle cycles carry nop, plus cke/odt and buffer strobes
 */
module cmd_slot_encoder (
    input  logic                             mclk,
    input  logic                             rst_in,
    input  logic                             issue,
    input  phy_cmd_pkg::cmd_word_t           issue_word,
    input  logic                             ddr_cke,
    output logic [2*phy_cmd_pkg::ADDR_W-1:0] phy_a,
    output logic [2*phy_cmd_pkg::BANK_W-1:0] phy_ba,
    output logic [1:0]                       phy_ras,   // bit 1 first half
    output logic [1:0]                       phy_cas,
    output logic [1:0]                       phy_we,
    output logic [1:0]                       phy_cke,
    output logic [1:0]                       phy_odt,
    output logic                             buf_wr,
    output logic                             buf_rd
);

    logic [2:0] rcw_n;          // active low {ras,cas,we}
    logic [2:0] first_rcw;
    logic [2:0] second_rcw;
    logic       cke_r;          // cke of last issued word
    logic       odt_r;

    assign rcw_n      = ~issue_word.ddr.rcw;
    assign first_rcw  = (issue && issue_word.ddr.sel)  ? rcw_n : 3'b111;
    assign second_rcw = (issue && !issue_word.ddr.sel) ? rcw_n : 3'b111;

    assign phy_cke = {2{cke_r}};    // same in both halves
    assign phy_odt = {2{odt_r}};

    // address/bank duplicated, kept over idle cycles
    always_ff @(posedge mclk) begin
        if (issue) begin
            phy_a  <= {2{issue_word.ddr.addr}};
            phy_ba <= {2{issue_word.ddr.bank}};
        end
    end

    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            phy_ras <= 2'b11;
            phy_cas <= 2'b11;
            phy_we  <= 2'b11;
            cke_r   <= 1'b0;
            odt_r   <= 1'b0;
            buf_wr  <= 1'b0;
            buf_rd  <= 1'b0;
        end else begin
            phy_ras <= {first_rcw[2], second_rcw[2]};
            phy_cas <= {first_rcw[1], second_rcw[1]};
            phy_we  <= {first_rcw[0], second_rcw[0]};
            buf_wr  <= issue && issue_word.ddr.buf_wr;  // strobes only with a word
            buf_rd  <= issue && issue_word.ddr.buf_rd;
            if (issue) begin
                cke_r <= issue_word.ddr.cke_dis ^ ddr_cke;
                odt_r <= issue_word.ddr.odt;
            end
        end
    end

endmodule

/* hdl/dq_tri_sequencer.sv */
`timescale 1ns/10ps
/*
 * dq/dqs tristate sequencer
 * tracks the tristate state per lane and inserts the first/last
 * half-cycle patterns on each transition, plus dci disable
 */
module dq_tri_sequencer (
    input  logic                          mclk,
    input  logic                          rst_in,
    input  logic                          issue,
    input  phy_cmd_pkg::cmd_word_t        issue_word,
    output logic [phy_cmd_pkg::TRI_W-1:0] dq_tri,
    output logic [phy_cmd_pkg::TRI_W-1:0] dqs_tri,
    output logic                          dci_dis
);

    logic dq_tri_st;        // 1 = lane tristated
    logic dqs_tri_st;
    logic dq_tri_nxt;
    logic dqs_tri_nxt;

    // output word for one lane given old and new state
    function automatic logic [phy_cmd_pkg::TRI_W-1:0] tri_word(
        input logic       prev,
        input logic       nxt,
        input logic [3:0] first,
        input logic [3:0] last
    );
        if (prev == nxt) begin
            return {phy_cmd_pkg::TRI_W{nxt}};   // steady
        end else if (prev) begin
            return {first, first};              // tri -> driven
        end else begin
            return {last, last};                // driven -> tri
        end
    endfunction

    assign dq_tri_nxt  = issue ? ~issue_word.ddr.dq_en  : dq_tri_st;   // hold when idle
    assign dqs_tri_nxt = issue ? ~issue_word.ddr.dqs_en : dqs_tri_st;

    always_ff @(posedge mclk or posedge rst_in) begin
        if (rst_in) begin
            dq_tri_st  <= 1'b1;
            dqs_tri_st <= 1'b1;
            dq_tri     <= '1;
            dqs_tri    <= '1;
            dci_dis    <= 1'b1;
        end else begin
            dq_tri_st  <= dq_tri_nxt;
            dqs_tri_st <= dqs_tri_nxt;
            dq_tri  <= tri_word(dq_tri_st, dq_tri_nxt,
                                phy_cmd_pkg::DQ_TRI_FIRST, phy_cmd_pkg::DQ_TRI_LAST);
            dqs_tri <= tri_word(dqs_tri_st, dqs_tri_nxt,
                                phy_cmd_pkg::DQS_TRI_FIRST, phy_cmd_pkg::DQS_TRI_LAST);
            if (issue) begin
                dci_dis <= ~issue_word.ddr.dci_en;  // both dq and dqs
            end
        end
    end

endmodule

/* hdl/phy_cmd_top.sv */
`timescale 1ns/10ps
/*
 * DDR3 command sequencer top
 * fetches command words from external memory and turns them into
 * half-rate phy command slots, dq/dqs tristate words and buffer strobes
 */
module phy_cmd_top (
    input  logic                              mclk,
    input  logic                              rst_in,
    input  logic                              start,      // begin sequence at address 0
    input  logic                              ddr_cke,    // global cke, xor-ed per word
    input  phy_cmd_pkg::cmd_word_t            cmd_word,   // memory data, one cycle after cmd_rd
    output logic                              cmd_rd,
    output logic [phy_cmd_pkg::PC_W-1:0]      cmd_addr,
    output logic                              busy,
    output logic                              seq_done,
    output logic [2*phy_cmd_pkg::ADDR_W-1:0]  phy_a,
    output logic [2*phy_cmd_pkg::BANK_W-1:0]  phy_ba,
    output logic [1:0]                        phy_ras,    // active low, bit 1 first half
    output logic [1:0]                        phy_cas,
    output logic [1:0]                        phy_we,
    output logic [1:0]                        phy_cke,
    output logic [1:0]                        phy_odt,
    output logic [phy_cmd_pkg::TRI_W-1:0]     dq_tri,
    output logic [phy_cmd_pkg::TRI_W-1:0]     dqs_tri,
    output logic                              dci_dis,
    output logic                              buf_wr,
    output logic                              buf_rd
);

    logic                            issue;          // one per accepted word
    phy_cmd_pkg::cmd_word_t          issue_word;
    logic                            pause_load;
    logic [phy_cmd_pkg::PAUSE_W-1:0] pause_len;
    logic                            pause_expired;

    cmd_sequencer u_cmd_sequencer (
        .mclk          (mclk),
        .rst_in        (rst_in),
        .start         (start),
        .cmd_word      (cmd_word),
        .pause_expired (pause_expired),
        .cmd_rd        (cmd_rd),
        .cmd_addr      (cmd_addr),
        .issue         (issue),
        .issue_word    (issue_word),
        .pause_load    (pause_load),
        .pause_len     (pause_len),
        .busy          (busy),
        .seq_done      (seq_done)
    );

    pause_timer u_pause_timer (
        .mclk          (mclk),
        .rst_in        (rst_in),
        .pause_load    (pause_load),
        .pause_len     (pause_len),
        .pause_expired (pause_expired)
    );

    cmd_slot_encoder u_cmd_slot_encoder (
        .mclk       (mclk),
        .rst_in     (rst_in),
        .issue      (issue),
        .issue_word (issue_word),
        .ddr_cke    (ddr_cke),
        .phy_a      (phy_a),
        .phy_ba     (phy_ba),
        .phy_ras    (phy_ras),
        .phy_cas    (phy_cas),
        .phy_we     (phy_we),
        .phy_cke    (phy_cke),
        .phy_odt    (phy_odt),
        .buf_wr     (buf_wr),
        .buf_rd     (buf_rd)
    );

    dq_tri_sequencer u_dq_tri_sequencer (
        .mclk       (mclk),
        .rst_in     (rst_in),
        .issue      (issue),
        .issue_word (issue_word),
        .dq_tri     (dq_tri),
        .dqs_tri    (dqs_tri),
        .dci_dis    (dci_dis)
    );

endmodule

/* verif/tb_phy_cmd.sv */
`timescale 1ns/10ps
/*
 * phy_cmd_top testbench
 * command memory model, reference model of the slot, tristate and
 * pause rules, directed tests and a cycle limit
 */
module tb_phy_cmd;

    localparam int CYCLE_LIMIT = 2000;  // far above all tests together
    localparam int TAIL_CYCLES = 4;     // idle cycles checked after done

    logic mclk = 1'b0;
    logic rst_in;
    logic start;
    logic ddr_cke;
    phy_cmd_pkg::cmd_word_t cmd_word = '0;
    logic cmd_rd;
    logic [phy_cmd_pkg::PC_W-1:0] cmd_addr;
    logic busy;
    logic seq_done;
    logic [2*phy_cmd_pkg::ADDR_W-1:0] phy_a;
    logic [2*phy_cmd_pkg::BANK_W-1:0] phy_ba;
    logic [1:0] phy_ras;
    logic [1:0] phy_cas;
    logic [1:0] phy_we;
    logic [1:0] phy_cke;
    logic [1:0] phy_odt;
    logic [phy_cmd_pkg::TRI_W-1:0] dq_tri;
    logic [phy_cmd_pkg::TRI_W-1:0] dqs_tri;
    logic dci_dis;
    logic buf_wr;
    logic buf_rd;

    phy_cmd_pkg::cmd_word_t mem [0:255];    // command memory
    logic fetch_q = 1'b0;                   // read seen last cycle
    logic [phy_cmd_pkg::PC_W-1:0] fetch_addr = '0;
    phy_cmd_pkg::cmd_word_t ev_word[$];     // expected output cycles
    bit ev_issue[$];
    bit ev_rd[$];
    bit ev_busy[$];
    logic [phy_cmd_pkg::PC_W-1:0] ev_addr[$];   // fetch address when reading

    // reference state, reset values
    logic [2*phy_cmd_pkg::ADDR_W-1:0] r_a;
    logic [2*phy_cmd_pkg::BANK_W-1:0] r_ba;
    logic r_cke = 1'b0;
    logic r_odt = 1'b0;
    logic r_dq_st = 1'b1;       // tristated
    logic r_dqs_st = 1'b1;
    logic r_dci_dis = 1'b1;
    logic cur_cke = 1'b0;       // ddr_cke of running program
    bit addr_known = 1'b0;      // phy_a has no reset value
    logic [31:0] lcg = 32'h170e_e8cf;
    int cycles = 0;
    int done_cnt = 0;

    phy_cmd_top u_phy_cmd_top (.*);

    initial begin
        forever #2 mclk = ~mclk;    // 4 ns period
    end

    // data valid through the cycle after cmd_rd
    always @(negedge mclk) begin
        if (fetch_q) begin
            cmd_word <= mem[fetch_addr];
        end
        fetch_q    <= cmd_rd;
        fetch_addr <= cmd_addr;
    end

    always @(posedge mclk) begin
        if (seq_done) begin
            done_cnt <= done_cnt + 1;
        end
        cycles <= cycles + 1;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout, run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Simulation FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    function automatic logic [31:0] next_rand();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg;
    endfunction

    function automatic phy_cmd_pkg::cmd_word_t mk_ddr(input logic [14:0] a, input logic [2:0] ba,
                                                      input logic [2:0] rcw, input logic sel,
                                                      input logic odt, input logic cke_dis);
        phy_cmd_pkg::cmd_word_t w;
        w = '0;
        w.ddr.addr    = a;
        w.ddr.bank    = ba;
        w.ddr.rcw     = rcw;
        w.ddr.sel     = sel;
        w.ddr.odt     = odt;
        w.ddr.cke_dis = cke_dis;
        return w;
    endfunction

    function automatic phy_cmd_pkg::cmd_word_t mk_nop(input logic [5:0] p, input logic done);
        phy_cmd_pkg::cmd_word_t w;
        w = '0;
        w.nop.pause = p;
        w.nop.done  = done;
        return w;
    endfunction

    // fill pattern from the whole address, then program from 0
    task automatic clear_mem();
        for (int i = 0; i < 256; i++) begin
            mem[i] = phy_cmd_pkg::cmd_word_t'(32'(i) * 32'h9e37_79b9);
        end
    endtask

    task automatic fail_value(input string name, input string field, input string e,
                              input string a);
        $display("Fail %s %s expected %s actual %s", name, field, e, a);
        $display("Simulation FAILED");
        $fatal(1, "mismatch");
    endtask

    task automatic check_slots(input string name, input logic [2*phy_cmd_pkg::ADDR_W-1:0] a,
                               input logic [2*phy_cmd_pkg::BANK_W-1:0] ba,
                               input logic [1:0] ras, input logic [1:0] cas,
                               input logic [1:0] we, input logic [1:0] cke,
                               input logic [1:0] odt);
        if (addr_known && phy_a !== a)
            fail_value(name, "phy_a", $sformatf("%h", a), $sformatf("%h", phy_a));
        if (addr_known && phy_ba !== ba)
            fail_value(name, "phy_ba", $sformatf("%h", ba), $sformatf("%h", phy_ba));
        if ({phy_ras, phy_cas, phy_we} !== {ras, cas, we})
            fail_value(name, "ras/cas/we", $sformatf("%b", {ras, cas, we}),
                       $sformatf("%b", {phy_ras, phy_cas, phy_we}));
        if (phy_cke !== cke)
            fail_value(name, "phy_cke", $sformatf("%b", cke), $sformatf("%b", phy_cke));
        if (phy_odt !== odt)
            fail_value(name, "phy_odt", $sformatf("%b", odt), $sformatf("%b", phy_odt));
    endtask

    task automatic check_tri(input string name, input logic [phy_cmd_pkg::TRI_W-1:0] dq,
                             input logic [phy_cmd_pkg::TRI_W-1:0] dqs, input logic dci);
        if (dq_tri !== dq)
            fail_value(name, "dq_tri", $sformatf("%h", dq), $sformatf("%h", dq_tri));
        if (dqs_tri !== dqs)
            fail_value(name, "dqs_tri", $sformatf("%h", dqs), $sformatf("%h", dqs_tri));
        if (dci_dis !== dci)
            fail_value(name, "dci_dis", $sformatf("%b", dci), $sformatf("%b", dci_dis));
    endtask

    task automatic check_flag(input string name, input string field, input logic e,
                              input logic a);
        if (a !== e)
            fail_value(name, field, $sformatf("%b", e), $sformatf("%b", a));
    endtask

    task automatic check_addr(input string name, input logic [phy_cmd_pkg::PC_W-1:0] e);
        if (cmd_addr !== e)
            fail_value(name, "cmd_addr", $sformatf("%h", e), $sformatf("%h", cmd_addr));
    endtask

    // lane word from old and new tristate state
    function automatic logic [7:0] lane_word(input logic prev, input logic now,
                                             input logic [3:0] on_drive, input logic [3:0] on_tri);
        if (prev == now) return {8{now}};
        return now ? {on_tri, on_tri} : {on_drive, on_drive};
    endfunction

    // one output cycle, issued word or hold
    task automatic check_cycle(input string name, input bit iss,
                               input phy_cmd_pkg::cmd_word_t w, input bit rd, input bit bsy,
                               input logic [phy_cmd_pkg::PC_W-1:0] addr);
        logic [2:0] act;
        logic [2:0] first;
        logic [2:0] second;
        logic dq_now;
        logic dqs_now;
        logic [7:0] dqw;
        logic [7:0] dqsw;
        act    = iss ? ~w.ddr.rcw : 3'b111;
        first  = (iss && w.ddr.sel) ? act : 3'b111;
        second = (iss && !w.ddr.sel) ? act : 3'b111;
        dq_now  = iss ? ~w.ddr.dq_en : r_dq_st;
        dqs_now = iss ? ~w.ddr.dqs_en : r_dqs_st;
        dqw  = lane_word(r_dq_st, dq_now, phy_cmd_pkg::DQ_TRI_FIRST, phy_cmd_pkg::DQ_TRI_LAST);
        dqsw = lane_word(r_dqs_st, dqs_now, phy_cmd_pkg::DQS_TRI_FIRST,
                         phy_cmd_pkg::DQS_TRI_LAST);
        r_dq_st  = dq_now;
        r_dqs_st = dqs_now;
        if (iss) begin
            r_a        = {2{w.ddr.addr}};
            r_ba       = {2{w.ddr.bank}};
            r_cke      = w.ddr.cke_dis ^ cur_cke;
            r_odt      = w.ddr.odt;
            r_dci_dis  = ~w.ddr.dci_en;
            addr_known = 1'b1;
        end
        check_slots(name, r_a, r_ba, {first[2], second[2]}, {first[1], second[1]},
                    {first[0], second[0]}, {2{r_cke}}, {2{r_odt}});
        check_tri(name, dqw, dqsw, r_dci_dis);
        check_flag(name, "buf_wr", iss & w.ddr.buf_wr, buf_wr);
        check_flag(name, "buf_rd", iss & w.ddr.buf_rd, buf_rd);
        check_flag(name, "seq_done", iss && w.ddr.rcw == 3'b000 && w.nop.done, seq_done);
        check_flag(name, "busy", bsy, busy);
        check_flag(name, "cmd_rd", rd, cmd_rd);
        if (rd) begin
            check_addr(name, addr);
        end
    endtask

    // expected cycles from the program at address 0
    task automatic build_events();
        phy_cmd_pkg::cmd_word_t w;
        ev_word.delete();
        ev_issue.delete();
        ev_rd.delete();
        ev_busy.delete();
        ev_addr.delete();
        for (int pc = 0; pc < 256; pc++) begin
            w = mem[pc];
            ev_word.push_back(w);
            ev_issue.push_back(1'b1);
            ev_addr.push_back((phy_cmd_pkg::PC_W)'(pc + 2));   // two words ahead
            if (w.ddr.rcw == 3'b000 && w.nop.done) begin
                ev_rd.push_back(1'b0);      // fetch off, busy drops with done
                ev_busy.push_back(1'b0);
                break;
            end else if (w.ddr.rcw == 3'b000 && w.nop.pause != '0) begin
                ev_rd.push_back(1'b0);
                ev_busy.push_back(1'b1);
                for (int i = 0; i <= int'(w.nop.pause); i++) begin
                    ev_word.push_back(w);
                    ev_issue.push_back(1'b0);
                    ev_rd.push_back(i >= int'(w.nop.pause) - 1);    // refetch in last two
                    ev_busy.push_back(1'b1);
                    ev_addr.push_back((phy_cmd_pkg::PC_W)'(pc + 2 + i - int'(w.nop.pause)));
                end
            end else begin
                ev_rd.push_back(1'b1);
                ev_busy.push_back(1'b1);
            end
        end
    endtask

    task automatic run_program(input string name, input logic cke);
        build_events();
        @(negedge mclk);
        ddr_cke = cke;
        cur_cke = cke;
        start   = 1'b1;
        @(negedge mclk);
        start = 1'b0;
        @(negedge mclk);                    // word 0 returning
        for (int i = 0; i < ev_word.size(); i++) begin
            @(negedge mclk);
            check_cycle(name, ev_issue[i], ev_word[i], ev_rd[i], ev_busy[i], ev_addr[i]);
        end
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            @(negedge mclk);
            check_cycle(name, 1'b0, '0, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic test_reset_idle();
        for (int i = 0; i < 4; i++) begin
            @(negedge mclk);
            check_cycle("test_reset_idle", 1'b0, '0, 1'b0, 1'b0, '0);
        end
    endtask

    task automatic test_slot_encoding();
        clear_mem();
        mem[0] = mk_ddr(15'h1234, 3'd5, 3'b100, 1'b1, 1'b1, 1'b0);
        mem[1] = mk_ddr(15'h0abc, 3'd2, 3'b010, 1'b0, 1'b0, 1'b1);
        mem[2] = mk_ddr(15'h7fff, 3'd7, 3'b011, 1'b1, 1'b1, 1'b0);
        mem[3] = mk_ddr(15'h0000, 3'd0, 3'b111, 1'b0, 1'b0, 1'b1);
        mem[4] = mk_ddr(15'h5555, 3'd3, 3'b001, 1'b1, 1'b0, 1'b0);
        mem[5] = mk_nop(6'd0, 1'b1);
        run_program("test_slot_encoding", 1'b0);
        run_program("test_slot_encoding", 1'b1);    // same words, cke inverted
    endtask

    task automatic test_tri_patterns();
        logic [2:0] en [0:6];
        en = '{3'b111, 3'b111, 3'b010, 3'b000, 3'b101, 3'b011, 3'b000};  // dq,dqs,dci
        clear_mem();
        for (int i = 0; i < 7; i++) begin
            mem[i] = mk_ddr(15'h0100, 3'd1, 3'b101, 1'b1, 1'b0, 1'b0);
            {mem[i].ddr.dq_en, mem[i].ddr.dqs_en, mem[i].ddr.dci_en} = en[i];
        end
        mem[7] = mk_nop(6'd0, 1'b1);
        run_program("test_tri_patterns", 1'b0);
    endtask

    task automatic test_pause();
        clear_mem();
        mem[0] = mk_ddr(15'h0042, 3'd4, 3'b011, 1'b0, 1'b1, 1'b0);
        mem[0].ddr.buf_wr = 1'b1;
        mem[1] = mk_nop(6'd5, 1'b0);        // five cycle pause
        mem[2] = mk_ddr(15'h0043, 3'd4, 3'b010, 1'b1, 1'b0, 1'b0);
        mem[2].ddr.buf_rd = 1'b1;
        mem[3] = mk_nop(6'd0, 1'b1);
        run_program("test_pause", 1'b0);
    endtask

    task automatic test_random_stream();
        logic [31:0] r;
        int done_before;
        clear_mem();
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            mem[i] = phy_cmd_pkg::cmd_word_t'(next_rand());
            if (r[2:0] == 3'd0) begin
                mem[i].nop.rcw   = 3'b000;      // nop, pause 0 to 7
                mem[i].nop.done  = 1'b0;
                mem[i].nop.pause = {3'b000, r[6:4]};
            end else if (mem[i].ddr.rcw == 3'b000) begin
                mem[i].ddr.rcw = 3'b110;
            end
        end
        mem[40] = mk_nop(6'd0, 1'b1);
        done_before = done_cnt;
        run_program("test_random_stream", 1'b1);
        if (done_cnt != done_before + 1) begin
            fail_value("test_random_stream", "seq_done count", "1",
                       $sformatf("%0d", done_cnt - done_before));
        end
    endtask

    initial begin
        rst_in  = 1'b1;
        start   = 1'b0;
        ddr_cke = 1'b0;
        repeat (3) @(posedge mclk);
        @(negedge mclk);
        rst_in = 1'b0;
        test_reset_idle();
        test_slot_encoding();
        test_tri_patterns();
        test_pause();
        test_random_stream();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

/* phy_cmd.f */
hdl/phy_cmd_pkg.sv
hdl/pause_timer.sv
hdl/cmd_sequencer.sv
hdl/cmd_slot_encoder.sv
hdl/dq_tri_sequencer.sv
hdl/phy_cmd_top.sv
verif/tb_phy_cmd.sv

/* run_sim.sh */
#!/bin/sh
# build and run the phy_cmd testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_phy_cmd \
    -f phy_cmd.f \
    -o sim_phy_cmd
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/sim_phy_cmd
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
